// ==== source/bus_pkg.sv ====
// Wishbone widths and the layout of the key log in system memory
// Imported by the bus master, the terminal controller and the top level

`default_nettype none

package bus_pkg;

   // Bus widths
   localparam int WB_ADR_W = 32;
   localparam int WB_DAT_W = 32;

   typedef logic [WB_ADR_W-1:0] wb_adr_t;
   typedef logic [WB_DAT_W-1:0] wb_dat_t;

   // Every transfer moves a whole word
   localparam logic [WB_DAT_W/8-1:0] WB_SEL_FULL = '1;

   // Log ring in system memory with one word per slot
   localparam wb_adr_t LOG_BASE   = 32'h3000_0000;
   localparam int      LOG_DEPTH  = 8;
   localparam int      LOG_SLOT_W = $clog2(LOG_DEPTH);

   // Press count in the upper part of a log word
   localparam int LOG_CNT_W = WB_DAT_W - 8;

endpackage

`default_nettype wire

// ==== source/term_pkg.sv ====
// Keypad geometry, scan timing and HD44780 definitions for the terminal
// Imported by the keypad scanner, the terminal controller and the top level

`default_nettype none

package term_pkg;

   // Matrix size
   localparam int KP_ROWS  = 4;
   localparam int KP_COLS  = 4;
   localparam int KP_ROW_W = $clog2(KP_ROWS);
   localparam int KP_COL_W = $clog2(KP_COLS);

   // Key code is row times 4 plus column
   typedef logic [KP_ROW_W+KP_COL_W-1:0] key_code_t;

   // Clock cycles spent on each column
   localparam int SCAN_DIV   = 16;
   localparam int SCAN_DIV_W = $clog2(SCAN_DIV);

   // Full scans a key must be seen in before it counts
   localparam int DEBOUNCE_PASSES = 2;
   localparam int PASS_CNT_W      = $clog2(DEBOUNCE_PASSES + 1);

   // Function keys
   localparam key_code_t KEY_STAR = 4'd12;
   localparam key_code_t KEY_HASH = 4'd14;

   typedef logic [7:0] lcd_byte_t;

   // HD44780 commands for an 8-bit bus with two lines
   localparam lcd_byte_t LCD_FUNC_SET = 8'h38;
   localparam lcd_byte_t LCD_DISP_ON  = 8'h0C;
   localparam lcd_byte_t LCD_CLEAR    = 8'h01;

   // Enable pulse and hold time after it
   localparam int LCD_EN_CYCLES  = 4;
   localparam int LCD_GAP_CYCLES = 8;
   localparam int LCD_CNT_W      = $clog2(LCD_EN_CYCLES + LCD_GAP_CYCLES + 1);

   // Printed legend row by row, key 0 in the top byte
   localparam logic [8*KP_ROWS*KP_COLS-1:0] KEY_LEGEND = "123A456B789C*0#D";

   function automatic lcd_byte_t key_ascii(input key_code_t code);
      return KEY_LEGEND[8*(KP_ROWS*KP_COLS-1-code) +: 8];
   endfunction

endpackage

`default_nettype wire

// ==== source/keypad_scanner.sv ====
// Scans a 4x4 matrix keypad one column at a time and debounces presses
// Each press gives one key_valid_o pulse and the next needs a full release

`timescale 1ns/1ps
`default_nettype none

module keypad_scanner
   import term_pkg::*;
(
   input  logic               clk,
   input  logic               arst_n_i,
   input  logic               en_i,
   input  logic [KP_ROWS-1:0] rows_i,
   output logic [KP_COLS-1:0] cols_o,
   output logic               key_valid_o,
   output key_code_t          key_o
);

   logic [SCAN_DIV_W-1:0] div_cnt;
   logic                  step;
   logic [KP_COLS-1:0]    col_n;
   logic [KP_COL_W-1:0]   col_idx;
   logic [KP_ROW_W-1:0]   row_idx;
   logic                  row_hit;
   logic                  pass_end;
   logic                  pass_hit;
   key_code_t             pass_code;
   logic                  hit_now;
   key_code_t             code_now;
   key_code_t             cand_code;
   logic [PASS_CNT_W-1:0] conf_cnt;
   logic                  wait_release;

   // Last cycle on a column, rows have settled by now
   assign step = (div_cnt == SCAN_DIV_W'(SCAN_DIV - 1));

   // Divider and one-cold column pointer
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         div_cnt <= '0;
         col_n   <= {{(KP_COLS-1){1'b1}}, 1'b0};
      end else if (en_i) begin
         div_cnt <= step ? '0 : div_cnt + 1'b1;
         if (step) begin
            col_n <= {col_n[KP_COLS-2:0], col_n[KP_COLS-1]};
         end
      end else begin
         div_cnt <= '0;
      end
   end

   // All columns released while disabled
   assign cols_o = en_i ? col_n : '1;

   // Encode active column and lowest pulled-down row
   always_comb begin
      col_idx = '0;
      row_idx = '0;
      row_hit = 1'b0;
      for (int c = 0; c < KP_COLS; c++) begin
         if (!col_n[c]) begin
            col_idx = KP_COL_W'(c);
         end
      end
      for (int r = KP_ROWS - 1; r >= 0; r--) begin
         if (!rows_i[r]) begin
            row_hit = 1'b1;
            row_idx = KP_ROW_W'(r);
         end
      end
   end

   // Pass ends on the step of the last column
   assign pass_end = step && !col_n[KP_COLS-1];
   assign hit_now  = pass_hit || row_hit;
   // First key found in scan order wins
   assign code_now = pass_hit ? pass_code : {row_idx, col_idx};

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pass_hit     <= 1'b0;
         conf_cnt     <= '0;
         wait_release <= 1'b0;
         key_valid_o  <= 1'b0;
      end else begin
         key_valid_o <= 1'b0;
         if (!en_i) begin
            pass_hit <= 1'b0;
            conf_cnt <= '0;
         end else if (pass_end) begin
            pass_hit <= 1'b0;
            if (wait_release) begin
               // Released once a whole pass reads every row high
               wait_release <= hit_now;
               conf_cnt     <= '0;
            end else if (!hit_now) begin
               conf_cnt <= '0;
            end else if (conf_cnt != '0 && code_now != cand_code) begin
               // Another key showed up so count it from one
               conf_cnt <= PASS_CNT_W'(1);
            end else if (conf_cnt == PASS_CNT_W'(DEBOUNCE_PASSES - 1)) begin
               key_valid_o  <= 1'b1;
               wait_release <= 1'b1;
               conf_cnt     <= '0;
            end else begin
               conf_cnt <= conf_cnt + 1'b1;
            end
         end else if (step && row_hit) begin
            pass_hit <= 1'b1;
         end
      end
   end

   // Key codes seen during the pass
   always_ff @(posedge clk) begin
      if (step && row_hit && !pass_hit) begin
         pass_code <= {row_idx, col_idx};
      end
      if (pass_end && hit_now) begin
         cand_code <= code_now;
      end
      if (pass_end) begin
         key_o <= code_now;
      end
   end

   // Exactly one column pulled low while scanning
   a_cols_one_cold: assert property (@(posedge clk) disable iff (!arst_n_i)
      en_i |-> $onehot(~cols_o));

endmodule

`default_nettype wire

// ==== source/wishbone_manager.sv ====
// Single-transfer Wishbone master for the terminal controller
// A read or write pulse starts one bus cycle and busy_o covers it

`timescale 1ns/1ps
`default_nettype none

module wishbone_manager
   import bus_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n_i,
   // Requests from the controller
   input  logic                  write_req_i,
   input  logic                  read_req_i,
   input  wb_adr_t               adr_i,
   input  wb_dat_t               wdata_i,
   output logic                  busy_o,
   output wb_dat_t               rdata_o,
   // Wishbone side
   input  wb_dat_t               dat_i,
   input  logic                  ack_i,
   output wb_adr_t               adr_o,
   output wb_dat_t               dat_o,
   output logic [WB_DAT_W/8-1:0] sel_o,
   output logic                  we_o,
   output logic                  stb_o,
   output logic                  cyc_o
);

   typedef enum logic {WB_IDLE, WB_ACTIVE} wb_state_t;

   wb_state_t state;
   logic      req;

   assign req   = write_req_i || read_req_i;
   assign sel_o = WB_SEL_FULL;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state  <= WB_IDLE;
         cyc_o  <= 1'b0;
         stb_o  <= 1'b0;
         we_o   <= 1'b0;
         busy_o <= 1'b0;
      end else begin
         case (state)
            WB_IDLE: begin
               busy_o <= req;
               if (req) begin
                  state <= WB_ACTIVE;
                  cyc_o <= 1'b1;
                  stb_o <= 1'b1;
                  we_o  <= write_req_i;
               end
            end
            WB_ACTIVE: begin
               // Stays busy through the cycle after the ack
               busy_o <= 1'b1;
               // Slave stretches the cycle by holding off ack
               if (ack_i) begin
                  state <= WB_IDLE;
                  cyc_o <= 1'b0;
                  stb_o <= 1'b0;
                  we_o  <= 1'b0;
               end
            end
         endcase
      end
   end

   // Address and data held for the whole cycle
   always_ff @(posedge clk) begin
      if (state == WB_IDLE && req) begin
         adr_o <= adr_i;
         dat_o <= wdata_i;
      end
      // Read data valid when busy drops
      if (state == WB_ACTIVE && ack_i) begin
         rdata_o <= dat_i;
      end
   end

   // Strobe, direction and payload held inside the cycle until the ack
   a_hold_until_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
      stb_o && !ack_i |=> stb_o && cyc_o && $stable({we_o, adr_o, dat_o}));

   // Controller waits for the manager to go idle
   a_req_when_free: assert property (@(posedge clk) disable iff (!arst_n_i)
      req |-> !busy_o);

endmodule

`default_nettype wire

// ==== source/team_01_cpu.sv ====
// Terminal controller of the keypad terminal
// Runs LCD power-up, logs keys over Wishbone, reads back on '#' and clears on '*'

`timescale 1ns/1ps
`default_nettype none

module team_01_cpu
   import bus_pkg::*, term_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n_i,
   input  logic      en_i,
   // Keypad scanner
   input  logic      key_valid_i,
   input  key_code_t key_i,
   // Wishbone manager
   input  logic      busy_i,
   input  wb_dat_t   rdata_i,
   output logic      write_req_o,
   output logic      read_req_o,
   output wb_adr_t   adr_o,
   output wb_dat_t   wdata_o,
   // LCD pins
   output logic      lcd_en_o,
   output logic      lcd_rs_o,
   output lcd_byte_t lcd_data_o
);

   typedef enum logic [2:0] {S_INIT, S_IDLE, S_REQ, S_BUS, S_LCD} cpu_state_t;

   cpu_state_t            state;
   logic [1:0]            init_idx;
   lcd_byte_t             init_cmd;
   logic [LCD_CNT_W-1:0]  lcd_cnt;
   logic                  lcd_last;
   logic                  rd_pending;
   logic [LOG_SLOT_W-1:0] wr_slot;
   logic [LOG_SLOT_W-1:0] last_slot;
   logic [LOG_CNT_W-1:0]  press_cnt;
   logic                  accept;
   logic                  is_star;
   logic                  is_hash;
   wb_adr_t               wr_adr;
   wb_adr_t               rd_adr;

   // Power-up command sequence
   always_comb begin
      case (init_idx)
         2'd0:    init_cmd = LCD_FUNC_SET;
         2'd1:    init_cmd = LCD_DISP_ON;
         default: init_cmd = LCD_CLEAR;
      endcase
   end

   // Strobes outside idle are dropped
   assign accept  = (state == S_IDLE) && en_i && key_valid_i;
   assign is_star = (key_i == KEY_STAR);
   assign is_hash = (key_i == KEY_HASH);

   // Most recent write sits one slot behind the next free one
   assign last_slot = wr_slot - LOG_SLOT_W'(1);
   assign wr_adr    = LOG_BASE + wb_adr_t'({wr_slot, 2'b00});
   assign rd_adr    = LOG_BASE + wb_adr_t'({last_slot, 2'b00});

   // End of enable pulse plus gap
   assign lcd_last = (lcd_cnt == LCD_CNT_W'(LCD_EN_CYCLES + LCD_GAP_CYCLES));

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state       <= S_INIT;
         init_idx    <= '0;
         lcd_cnt     <= '0;
         lcd_en_o    <= 1'b0;
         lcd_rs_o    <= 1'b0;
         lcd_data_o  <= '0;
         rd_pending  <= 1'b0;
         wr_slot     <= '0;
         press_cnt   <= '0;
         write_req_o <= 1'b0;
         read_req_o  <= 1'b0;
      end else begin
         write_req_o <= 1'b0;
         read_req_o  <= 1'b0;
         case (state)
            S_INIT: begin
               if (en_i) begin
                  lcd_rs_o   <= 1'b0;
                  lcd_data_o <= init_cmd;
                  init_idx   <= init_idx + 1'b1;
                  state      <= S_LCD;
               end
            end
            S_IDLE: begin
               if (accept) begin
                  if (is_star) begin
                     // Clear screen and restart the log without bus traffic
                     lcd_rs_o   <= 1'b0;
                     lcd_data_o <= LCD_CLEAR;
                     wr_slot    <= '0;
                     press_cnt  <= '0;
                     state      <= S_LCD;
                  end else if (is_hash) begin
                     // Empty log means nothing to read back
                     if (press_cnt != '0) begin
                        read_req_o <= 1'b1;
                        rd_pending <= 1'b1;
                        state      <= S_REQ;
                     end
                  end else begin
                     write_req_o <= 1'b1;
                     rd_pending  <= 1'b0;
                     wr_slot     <= wr_slot + 1'b1;
                     press_cnt   <= press_cnt + 1'b1;
                     state       <= S_REQ;
                  end
               end
            end
            S_REQ: begin
               // busy_i rises one cycle after the request
               state <= S_BUS;
            end
            S_BUS: begin
               if (!busy_i) begin
                  lcd_rs_o   <= 1'b1;
                  lcd_data_o <= rd_pending ? rdata_i[7:0] : wdata_o[7:0];
                  state      <= S_LCD;
               end
            end
            S_LCD: begin
               // Data set on entry so enable rises a cycle later
               lcd_cnt  <= lcd_last ? '0 : lcd_cnt + 1'b1;
               lcd_en_o <= (lcd_cnt < LCD_CNT_W'(LCD_EN_CYCLES));
               if (lcd_last) begin
                  state <= (init_idx == 2'd3) ? S_IDLE : S_INIT;
               end
            end
            default: state <= S_INIT;
         endcase
      end
   end

   // Payload of the accepted key stays put until the manager takes it
   always_ff @(posedge clk) begin
      if (accept) begin
         adr_o   <= is_hash ? rd_adr : wr_adr;
         // Count in the upper bits and the character below
         wdata_o <= {press_cnt + LOG_CNT_W'(1), key_ascii(key_i)};
      end
   end

   // Character lines must not move under the enable pulse
   a_lcd_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
      lcd_en_o |-> $stable({lcd_rs_o, lcd_data_o}));

endmodule

`default_nettype wire

// ==== source/team_01.sv ====
// Top of the keypad terminal user area
// Wires scanner, controller and Wishbone manager and maps the GPIO pads

`timescale 1ns/1ps
`default_nettype none

module team_01
   import bus_pkg::*, term_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  logic                  en_i,
   // Breakout board pads with active low output enables
   input  logic [33:0]           gpio_in_i,
   output logic [33:0]           gpio_out_o,
   output logic [33:0]           gpio_oeb_o,
   // Wishbone to the management core
   input  wb_dat_t               dat_i,
   input  logic                  ack_i,
   output wb_adr_t               adr_o,
   output wb_dat_t               dat_o,
   output logic [WB_DAT_W/8-1:0] sel_o,
   output logic                  we_o,
   output logic                  stb_o,
   output logic                  cyc_o
);

   logic [KP_COLS-1:0] cols;
   logic               key_valid;
   key_code_t          key;
   logic               write_req;
   logic               read_req;
   wb_adr_t            req_adr;
   wb_dat_t            req_wdata;
   logic               busy;
   wb_dat_t            rdata;
   logic               lcd_en;
   logic               lcd_rs;
   lcd_byte_t          lcd_data;

   keypad_scanner scanner (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .en_i        (en_i),
      .rows_i      (gpio_in_i[15:12]),
      .cols_o      (cols),
      .key_valid_o (key_valid),
      .key_o       (key)
   );

   wishbone_manager wb_manager (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .write_req_i (write_req),
      .read_req_i  (read_req),
      .adr_i       (req_adr),
      .wdata_i     (req_wdata),
      .busy_o      (busy),
      .rdata_o     (rdata),
      .dat_i       (dat_i),
      .ack_i       (ack_i),
      .adr_o       (adr_o),
      .dat_o       (dat_o),
      .sel_o       (sel_o),
      .we_o        (we_o),
      .stb_o       (stb_o),
      .cyc_o       (cyc_o)
   );

   team_01_cpu cpu (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .en_i        (en_i),
      .key_valid_i (key_valid),
      .key_i       (key),
      .busy_i      (busy),
      .rdata_i     (rdata),
      .write_req_o (write_req),
      .read_req_o  (read_req),
      .adr_o       (req_adr),
      .wdata_o     (req_wdata),
      .lcd_en_o    (lcd_en),
      .lcd_rs_o    (lcd_rs),
      .lcd_data_o  (lcd_data)
   );

   // Pad outputs with unused pads low
   always_comb begin
      gpio_out_o        = '0;
      gpio_out_o[1]     = lcd_en;
      gpio_out_o[2]     = lcd_rs;
      gpio_out_o[3]     = 1'b0;    // lcd_rw held low for write only
      gpio_out_o[11:4]  = lcd_data;
      gpio_out_o[19:16] = cols;
   end

   // LCD pads and columns drive, rows and spare pads are inputs
   always_comb begin
      gpio_oeb_o        = '1;
      gpio_oeb_o[11:1]  = '0;
      gpio_oeb_o[19:16] = '0;
   end

endmodule

`default_nettype wire

// ==== verif/team_01_tb.sv ====
// Testbench for the keypad terminal top level
// Models the keypad matrix, a Wishbone memory with random ack delay and the LCD
// pins, and checks each LCD write and bus transfer against a model of the log

`timescale 1ns/1ps
`default_nettype none

module team_01_tb
   import bus_pkg::*, term_pkg::*;
();

   localparam int CLK_PERIOD     = 100;
   localparam int RESET_CYCLES   = 10;
   localparam int PASS_CYCLES    = KP_COLS * SCAN_DIV;
   // Hold and release times in full scan passes
   localparam int SHORT_HOLD     = 4;
   localparam int LONG_HOLD      = 10;
   localparam int RELEASE_PASSES = 3;
   localparam int NUM_PRESSES    = 18;
   // Function keys in the legend, row 3
   localparam int STAR_CODE      = 12;
   localparam int HASH_CODE      = 14;
   // Longest bus cycle plus one enable pulse and its gap
   localparam int BUS_LCD_CYCLES = 12 + LCD_EN_CYCLES + LCD_GAP_CYCLES;
   localparam int PRESS_CYCLES   = (LONG_HOLD + RELEASE_PASSES) * PASS_CYCLES + BUS_LCD_CYCLES;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + 3 * BUS_LCD_CYCLES
                                  + NUM_PRESSES * PRESS_CYCLES;

   logic                  clk;
   logic                  arst_n;
   logic                  en;
   logic [33:0]           gpio_in;
   logic [33:0]           gpio_out;
   logic [33:0]           gpio_oeb;
   wb_dat_t               wb_rdat;
   logic                  wb_ack;
   wb_adr_t               wb_adr;
   wb_dat_t               wb_wdat;
   logic [WB_DAT_W/8-1:0] wb_sel;
   logic                  wb_we;
   logic                  wb_stb;
   logic                  wb_cyc;

   logic                  lcd_en;
   logic                  lcd_rs;
   lcd_byte_t             lcd_data;
   logic [KP_COLS-1:0]    cols;
   logic [KP_ROWS-1:0]    rows;

   // Pressed key of the keypad model
   logic                  key_down;
   logic [1:0]            key_row;
   logic [1:0]            key_col;

   // Log as the testbench expects it
   int                    log_count;
   lcd_byte_t             last_char;
   int                    key_codes [10];

   logic [15:0]           lfsr;
   wb_dat_t               mem [wb_adr_t];

   // Expected results and what the monitors saw
   logic [8:0]            exp_lcd [$];
   logic                  exp_we [$];
   wb_adr_t               exp_adr [$];
   wb_dat_t               exp_dat [$];
   logic [8:0]            seen_lcd [$];
   logic                  seen_we [$];
   wb_adr_t               seen_adr [$];
   wb_dat_t               seen_dat [$];

   team_01 team_01_inst (
      .clk        (clk),
      .arst_n_i   (arst_n),
      .en_i       (en),
      .gpio_in_i  (gpio_in),
      .gpio_out_o (gpio_out),
      .gpio_oeb_o (gpio_oeb),
      .dat_i      (wb_rdat),
      .ack_i      (wb_ack),
      .adr_o      (wb_adr),
      .dat_o      (wb_wdat),
      .sel_o      (wb_sel),
      .we_o       (wb_we),
      .stb_o      (wb_stb),
      .cyc_o      (wb_cyc)
   );

   assign lcd_en   = gpio_out[1];
   assign lcd_rs   = gpio_out[2];
   assign lcd_data = gpio_out[11:4];
   assign cols     = gpio_out[19:16];

   // Keypad matrix, pressed row follows its column
   always_comb begin
      rows = '1;
      if (key_down && !cols[key_col]) begin
         rows[key_row] = 1'b0;
      end
      gpio_in = {18'b0, rows, 12'b0};
   end

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Address of the slot that holds press number count
   function automatic wb_adr_t log_adr(input int count);
      return LOG_BASE + wb_adr_t'(4 * ((count - 1) % LOG_DEPTH));
   endfunction

   // Legend read row by row from the top left key
   function automatic lcd_byte_t key_char(input int code);
      string legend;
      legend = "123A456B789C*0#D";
      return legend[code];
   endfunction

   function automatic wb_dat_t log_word(input int count, input int code);
      return {LOG_CNT_W'(count), key_char(code)};
   endfunction

   function automatic logic [8:0] lcd_entry(input logic rs, input lcd_byte_t data);
      return {rs, data};
   endfunction

   // LCD enable, rs, rw and data on pads 1 to 11, columns on 16 to 19
   function automatic logic [33:0] output_pads();
      logic [33:0] mask;
      mask = '0;
      for (int p = 1; p <= 11; p++) begin
         mask[p] = 1'b1;
      end
      for (int p = 16; p <= 19; p++) begin
         mask[p] = 1'b1;
      end
      return mask;
   endfunction

   // Fibonacci LFSR x^16+x^14+x^13+x^11, one step per bit
   function automatic int take_bits(input int n);
      int   val;
      logic fb;
      val = 0;
      for (int i = 0; i < n; i++) begin
         val  = (val << 1) | int'(lfsr[15]);
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
      end
      return val;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_lcd(input logic rs_got, input logic rs_exp,
                            input lcd_byte_t data_got, input lcd_byte_t data_exp);
      if (rs_got !== rs_exp) begin
         report_failure($sformatf("mismatch at %0d ns: lcd_rs is %0b, expected %0b",
                                  $time, rs_got, rs_exp));
      end
      if (data_got !== data_exp) begin
         report_failure($sformatf("mismatch at %0d ns: lcd_data is 0x%h, expected 0x%h",
                                  $time, data_got, data_exp));
      end
   endtask

   task automatic check_adr(input string name, input wb_adr_t got, input wb_adr_t exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch at %0d ns: %s is 0x%h, expected 0x%h",
                                  $time, name, got, exp));
      end
   endtask

   task automatic check_dat(input string name, input wb_dat_t got, input wb_dat_t exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch at %0d ns: %s is 0x%h, expected 0x%h",
                                  $time, name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch at %0d ns: %s is %0b, expected %0b",
                                  $time, name, got, exp));
      end
   endtask

   task automatic check_sel(input string name, input logic [WB_DAT_W/8-1:0] got,
                            input logic [WB_DAT_W/8-1:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch at %0d ns: %s is 0x%h, expected 0x%h",
                                  $time, name, got, exp));
      end
   endtask

   task automatic check_pads(input string name, input logic [33:0] got,
                             input logic [33:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch at %0d ns: %s is 0x%h, expected 0x%h",
                                  $time, name, got, exp));
      end
   endtask

   // Output enables and every pad that must stay low
   task automatic check_pad_map();
      logic [33:0] live;
      live    = output_pads();
      // lcd_rw is tied low like the spare pads
      live[3] = 1'b0;
      check_pads("gpio_oeb_o", gpio_oeb, ~output_pads());
      check_pads("gpio_out_o spare pads", gpio_out & ~live, '0);
   endtask

   task automatic wait_for_expected();
      while (exp_lcd.size() != 0 || exp_we.size() != 0) begin
         @(posedge clk);
      end
   endtask

   // Press, hold until all results are in, then release for full passes
   task automatic press_key(input int code, input int hold_passes);
      @(posedge clk);
      #1;
      key_row  = 2'(code / 4);
      key_col  = 2'(code % 4);
      key_down = 1'b1;
      repeat (hold_passes * PASS_CYCLES) @(posedge clk);
      wait_for_expected();
      #1;
      key_down = 1'b0;
      repeat (RELEASE_PASSES * PASS_CYCLES) @(posedge clk);
   endtask

   task automatic log_key(input int code, input int hold_passes);
      log_count = log_count + 1;
      last_char = key_char(code);
      exp_we.push_back(1'b1);
      exp_adr.push_back(log_adr(log_count));
      exp_dat.push_back(log_word(log_count, code));
      exp_lcd.push_back(lcd_entry(1'b1, last_char));
      press_key(code, hold_passes);
   endtask

   // Empty log gives no read and no echo
   task automatic read_back();
      if (log_count > 0) begin
         exp_we.push_back(1'b0);
         exp_adr.push_back(log_adr(log_count));
         exp_dat.push_back('0);
         exp_lcd.push_back(lcd_entry(1'b1, last_char));
      end
      press_key(HASH_CODE, SHORT_HOLD);
   endtask

   task automatic clear_log();
      log_count = 0;
      exp_lcd.push_back(lcd_entry(1'b0, 8'h01));
      press_key(STAR_CODE, SHORT_HOLD);
   endtask

   // LCD capture on the falling enable
   always @(negedge lcd_en) begin
      if (arst_n) begin
         seen_lcd.push_back({lcd_rs, lcd_data});
      end
   end

   // Wishbone memory, ack after 0 to 3 cycles
   initial begin : memory_model
      int delay;
      wb_ack  = 1'b0;
      wb_rdat = '0;
      forever begin
         @(posedge clk);
         #1;
         if (wb_cyc && wb_stb) begin
            seen_we.push_back(wb_we);
            seen_adr.push_back(wb_adr);
            seen_dat.push_back(wb_wdat);
            // Every transfer is a full word
            check_sel("sel_o", wb_sel, 4'hF);
            if (wb_we) begin
               mem[wb_adr] = wb_wdat;
            end else if (!mem.exists(wb_adr)) begin
               report_failure("Wishbone read from a log address that was never written");
            end else begin
               wb_rdat = mem[wb_adr];
            end
            delay = take_bits(2);
            repeat (delay) begin
               @(posedge clk);
               #1;
               if (!(wb_cyc && wb_stb)) begin
                  report_failure("cyc_o or stb_o dropped before the ack");
               end
            end
            wb_ack = 1'b1;
            @(posedge clk);
            #1;
            wb_ack = 1'b0;
            if (wb_cyc) begin
               report_failure("cyc_o still high on the cycle after the ack");
            end
         end
      end
   end

   // Compare captures in order with the expected queues
   initial begin : compare_results
      logic [8:0] lcd_got;
      logic [8:0] lcd_exp;
      logic       we_exp;
      forever begin
         @(negedge clk);
         while (seen_lcd.size() != 0) begin
            lcd_got = seen_lcd.pop_front();
            if (exp_lcd.size() == 0) begin
               report_failure("LCD write arrived when none was expected");
            end
            lcd_exp = exp_lcd.pop_front();
            check_lcd(lcd_got[8], lcd_exp[8], lcd_got[7:0], lcd_exp[7:0]);
         end
         while (seen_we.size() != 0) begin
            if (exp_we.size() == 0) begin
               report_failure("Wishbone cycle started when no transfer was expected");
            end
            we_exp = exp_we.pop_front();
            check_bit("we_o", seen_we.pop_front(), we_exp);
            check_adr("adr_o", seen_adr.pop_front(), exp_adr.pop_front());
            if (we_exp) begin
               check_dat("dat_o", seen_dat.pop_front(), exp_dat.pop_front());
            end else begin
               void'(seen_dat.pop_front());
               void'(exp_dat.pop_front());
            end
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      report_failure("timeout, the DUT did not deliver the expected results in time");
   end

   initial begin : stimulus
      arst_n    = 1'b0;
      en        = 1'b1;
      key_down  = 1'b0;
      key_row   = '0;
      key_col   = '0;
      lfsr      = 16'd45613;
      log_count = 0;
      last_char = '0;
      key_codes = '{0, 1, 3, 4, 6, 8, 9, 11, 13, 15};
      // Power-up commands before anything else
      exp_lcd.push_back(lcd_entry(1'b0, 8'h38));
      exp_lcd.push_back(lcd_entry(1'b0, 8'h0C));
      exp_lcd.push_back(lcd_entry(1'b0, 8'h01));
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arst_n = 1'b1;
      wait_for_expected();
      @(negedge clk);
      check_pad_map();

      for (int i = 0; i < 3; i++) begin
         log_key(key_codes[i], SHORT_HOLD);
      end
      read_back();
      // Ten presses so the slot index wraps
      for (int i = 3; i < 10; i++) begin
         log_key(key_codes[i], SHORT_HOLD);
      end
      read_back();

      clear_log();
      read_back();
      log_key(key_codes[5], SHORT_HOLD);

      // Held key gives one entry only
      log_key(key_codes[2], LONG_HOLD);

      @(posedge clk);
      #1;
      en = 1'b0;
      press_key(key_codes[7], SHORT_HOLD);
      @(posedge clk);
      #1;
      en = 1'b1;
      log_key(key_codes[8], SHORT_HOLD);

      repeat (PASS_CYCLES) @(posedge clk);
      @(negedge clk);
      check_pad_map();
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== team_01.f ====
source/bus_pkg.sv
source/term_pkg.sv
source/keypad_scanner.sv
source/wishbone_manager.sv
source/team_01_cpu.sv
source/team_01.sv
verif/team_01_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the keypad terminal testbench with Verilator and runs it
# Usage: ./run_sim.sh from any directory, output goes to sim.log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module team_01_tb \
   -f team_01.f -o Vteam_01_tb

status=0
./obj_dir/Vteam_01_tb > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
   echo "Simulation FAILED"
   exit 1
fi
if [ "$status" -ne 0 ]; then
   echo "Simulation FAILED, simulator exit status $status"
   exit 1
fi
echo "Simulation PASSED"
